// ==== bench/wbuf_checker.sv ====
// Samples on the falling clock edge, expects commands only while busy_o is low
`timescale 1ns/1ps
`include "wbuf_settings.svh"

module wbuf_checker (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [8*16-1:0]          test_name_i,
  input  wbuf_ctrl_pkg::cmd_t      cmd_i,
  input  logic                     cmd_valid_i,
  input  wbuf_data_pkg::row_t      row_i,
  input  logic                     row_valid_i,
  input  wbuf_data_pkg::lane_idx_t gidx_i,
  input  logic                     gidx_repeat_i,
  input  wbuf_data_pkg::lanes_t    lanes_i,
  input  logic                     lanes_valid_i,
  input  logic                     busy_i,
  input  logic                     done_i,
  output int                       err_cnt_o,
  output int                       check_cnt_o
);

  localparam int H     = `WBUF_H;
  localparam int D     = `WBUF_D;
  localparam int Beats = `WBUF_C * `WBUF_ELMS;

  typedef enum int {M_IDLE, M_LOAD, M_STREAM} phase_e;

  wbuf_data_pkg::row_t      mem_m [H];  // Expected slot contents
  wbuf_data_pkg::lane_idx_t map_m [H];  // Slot each lane reads
  phase_e                   phase;
  int                       row_cnt;
  int                       beat;
  int                       width;
  int                       height;
  logic                     dequant;
  logic [H-1:0]             zero_mask;
  logic                     done_due;
  logic                     busy_exp;

  task automatic accept_cmd();
    if (busy_i) begin
      $display("Command issued while busy_o is high in test %0s", test_name_i);
      err_cnt_o++;
    end else begin
      case (cmd_i.opcode)
        wbuf_ctrl_pkg::OP_LOAD: begin
          phase   = M_LOAD;
          row_cnt = 0;
          width   = int'(cmd_i.width);
          height  = int'(cmd_i.height);
          dequant = cmd_i.dequant;
        end
        wbuf_ctrl_pkg::OP_STREAM: begin
          phase     = M_STREAM;
          beat      = 0;
          zero_mask = cmd_i.zero_set;
        end
        wbuf_ctrl_pkg::OP_CLEAR: begin
          for (int h = 0; h < H; h++) map_m[h] = wbuf_data_pkg::lane_idx_t'(h);
          done_due = 1'b1;
        end
        default: ;
      endcase
    end
  endtask

  task automatic store_row();
    wbuf_data_pkg::row_t padded;
    int                  slot;
    if (phase != M_LOAD) begin
      $display("Row offered outside a load phase in test %0s", test_name_i);
      err_cnt_o++;
    end else begin
      for (int d = 0; d < D; d++) begin
        padded[d] = '0;
        if (d < width && row_cnt < height) padded[d] = row_i[d];
      end
      slot = row_cnt;
      if (dequant) begin  // Lane of this row follows its group
        map_m[row_cnt] = gidx_i;
        slot           = int'(gidx_i);
      end
      if (!(dequant && gidx_repeat_i)) mem_m[slot] = padded;
      row_cnt++;
      if (row_cnt == H) begin
        phase    = M_IDLE;
        done_due = 1'b1;
      end
    end
  endtask

  task automatic compare_beat();
    wbuf_data_pkg::elem_t exp;
    if (phase != M_STREAM) begin
      $display("lanes_valid_o high outside a stream in test %0s", test_name_i);
      err_cnt_o++;
    end else begin
      for (int h = 0; h < H; h++) begin
        exp = zero_mask[h] ? '0 : mem_m[map_m[h]][beat];  // Beat k carries element k
        check_cnt_o++;
        if (lanes_i[h] !== exp) begin
          $display("[ERROR] %0s beat %0d lane %0d expected %h actual %h",
                   test_name_i, beat, h, exp, lanes_i[h]);
          err_cnt_o++;
        end
      end
      beat++;
      if (beat == Beats) begin
        phase    = M_IDLE;
        done_due = 1'b1;
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      for (int h = 0; h < H; h++) begin
        map_m[h] = wbuf_data_pkg::lane_idx_t'(h);
        mem_m[h] = '0;
      end
      phase       = M_IDLE;
      row_cnt     = 0;
      beat        = 0;
      width       = 0;
      height      = 0;
      dequant     = 1'b0;
      zero_mask   = '0;
      done_due    = 1'b0;
      busy_exp    = 1'b0;
      err_cnt_o   = 0;
      check_cnt_o = 0;
    end else begin
      // Busy from the cycle after an accepted command through its done cycle
      busy_exp = (phase != M_IDLE) || done_due;
      if (busy_i !== busy_exp) begin
        $display("[ERROR] %0s busy_o expected %b actual %b", test_name_i, busy_exp, busy_i);
        err_cnt_o++;
      end
      // done_o one cycle after a finished phase and never otherwise
      if (done_due && !done_i) begin
        $display("done_o missing after the end of a phase in test %0s", test_name_i);
        err_cnt_o++;
      end else if (!done_due && done_i) begin
        $display("done_o pulsed without a finished command in test %0s", test_name_i);
        err_cnt_o++;
      end
      done_due = 1'b0;
      if (cmd_valid_i) accept_cmd();
      if (row_valid_i) store_row();
      if (lanes_valid_i) compare_beat();
    end
  end

endmodule : wbuf_checker

// ==== bench/wbuf_tb.sv ====
// Run from the project root so the test data path resolves, test names are at most 16 characters
`timescale 1ns/1ps
`include "wbuf_settings.svh"

module wbuf_tb;

  localparam int unsigned H       = `WBUF_H;
  localparam int unsigned Timeout = 200;  // Cycles per wait

  logic                     clk;
  logic                     rst_n;
  wbuf_ctrl_pkg::cmd_t      cmd;
  logic                     cmd_valid;
  wbuf_data_pkg::row_t      row;
  logic                     row_valid;
  wbuf_data_pkg::lane_idx_t gidx;
  logic                     gidx_repeat;
  wbuf_data_pkg::lanes_t    lanes;
  logic                     lanes_valid;
  logic                     busy;
  logic                     done;
  logic [8*16-1:0]          test_name;
  int                       err_cnt;
  int                       check_cnt;
  int                       timeouts;
  int                       data_errs;
  int                       rows_sent;
  int                       fd;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Inputs change 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < Timeout) begin
      next_cycle();
      n++;
    end
    if (busy) begin
      $display("Timed out waiting for busy_o to drop in test %0s", test_name);
      timeouts++;
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (!done && n < Timeout) begin
      next_cycle();
      n++;
    end
    if (!done) begin
      $display("Timed out waiting for done_o in test %0s", test_name);
      timeouts++;
    end
  endtask

  task automatic issue_cmd(input wbuf_ctrl_pkg::opcode_e op, input int width,
                           input int height, input int dequant, input int zero_set);
    wait_idle();
    if (timeouts == 0) begin
      cmd.opcode   = op;
      cmd.width    = wbuf_ctrl_pkg::width_t'(width);
      cmd.height   = wbuf_ctrl_pkg::height_t'(height);
      cmd.dequant  = dequant[0];
      cmd.zero_set = zero_set[H-1:0];
      cmd_valid    = 1'b1;  // One-cycle pulse
      next_cycle();
      cmd_valid    = 1'b0;
    end
  endtask

  task automatic send_row(input int g, input int rep, input logic [`WBUF_DW-1:0] data);
    row         = data;
    gidx        = wbuf_data_pkg::lane_idx_t'(g);
    gidx_repeat = rep[0];
    row_valid   = 1'b1;
    next_cycle();
    row_valid   = 1'b0;
  endtask

  task automatic bad_record();
    $display("Malformed record in test data for test %0s", test_name);
    data_errs++;
  endtask

  // Reads the fields that follow the record kind and runs the step
  task automatic run_record(input logic [7:0] kind);
    int                  code;
    int                  a;
    int                  b;
    int                  c;
    logic [`WBUF_DW-1:0] data;
    case (kind)
      "L": begin
        code = $fscanf(fd, "%d %d %d", a, b, c);
        if (code != 3) begin
          bad_record();
        end else begin
          rows_sent = 0;
          issue_cmd(wbuf_ctrl_pkg::OP_LOAD, a, b, c, 0);
        end
      end
      "R": begin
        code = $fscanf(fd, "%d %d %h", a, b, data);
        if (code != 3) begin
          bad_record();
        end else begin
          send_row(a, b, data);
          rows_sent++;
          if (rows_sent == H) begin  // Last row of the load
            wait_done();
            rows_sent = 0;
          end
        end
      end
      "S": begin
        code = $fscanf(fd, "%h", a);
        if (code != 1) begin
          bad_record();
        end else begin
          issue_cmd(wbuf_ctrl_pkg::OP_STREAM, 0, 0, 0, a);
          if (timeouts == 0) wait_done();
        end
      end
      "C": begin
        issue_cmd(wbuf_ctrl_pkg::OP_CLEAR, 0, 0, 0, 0);
        if (timeouts == 0) wait_done();
      end
      default: bad_record();
    endcase
  endtask

  initial begin
    int               code;
    logic [8*16-1:0]  name;
    logic [7:0]       kind;
    logic [8*100-1:0] line;
    logic             stop;
    cmd         = '0;
    cmd_valid   = 1'b0;
    row         = '0;
    row_valid   = 1'b0;
    gidx        = '0;
    gidx_repeat = 1'b0;
    rst_n       = 1'b0;
    test_name   = '0;
    timeouts    = 0;
    data_errs   = 0;
    rows_sent   = 0;
    stop        = 1'b0;
    fd = $fopen("bench/wbuf_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test data file bench/wbuf_testdata.txt");
      data_errs++;
      stop = 1'b1;
    end
    repeat (8) @(posedge clk);
    #10;
    rst_n = 1'b1;
    while (!stop && timeouts == 0 && data_errs == 0) begin
      code = $fscanf(fd, "%s", name);
      if (code != 1) begin
        stop = 1'b1;  // End of file
      end else if (name == {{15{8'h00}}, "#"}) begin
        code = $fgets(line, fd);
      end else begin
        test_name = name;
        code = $fscanf(fd, "%s", kind);
        if (code != 1) begin
          bad_record();
        end else begin
          run_record(kind);
        end
      end
    end
    if (fd != 0) $fclose(fd);
    repeat (2) @(posedge clk);
    if (check_cnt == 0) $display("No lane output was checked");
    $display("Checks %0d, errors %0d, timeouts %0d, data file errors %0d",
             check_cnt, err_cnt, timeouts, data_errs);
    if (err_cnt == 0 && timeouts == 0 && data_errs == 0 && check_cnt > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  wbuf_top UUT (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .cmd_i         ( cmd         ),
    .cmd_valid_i   ( cmd_valid   ),
    .row_i         ( row         ),
    .row_valid_i   ( row_valid   ),
    .gidx_i        ( gidx        ),
    .gidx_repeat_i ( gidx_repeat ),
    .lanes_o       ( lanes       ),
    .lanes_valid_o ( lanes_valid ),
    .busy_o        ( busy        ),
    .done_o        ( done        )
  );

  wbuf_checker i_checker (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .test_name_i   ( test_name   ),
    .cmd_i         ( cmd         ),
    .cmd_valid_i   ( cmd_valid   ),
    .row_i         ( row         ),
    .row_valid_i   ( row_valid   ),
    .gidx_i        ( gidx        ),
    .gidx_repeat_i ( gidx_repeat ),
    .lanes_i       ( lanes       ),
    .lanes_valid_i ( lanes_valid ),
    .busy_i        ( busy        ),
    .done_i        ( done        ),
    .err_cnt_o     ( err_cnt     ),
    .check_cnt_o   ( check_cnt   )
  );

endmodule : wbuf_tb

// ==== bench/wbuf_testdata.txt ====
# L: name L width height dequant | R: name R gidx repeat row_hex, element 0 in the low bits
# S: name S zero_set_hex | C: name C
full_load L 4 4 0
full_load R 0 0 4003400240014000
full_load R 0 0 4013401240114010
full_load R 0 0 4023402240214020
full_load R 0 0 4033403240314030
full_load S 0
pad_small L 3 2 0
pad_small R 0 0 5a035a025a015a00
pad_small R 0 0 5b035b025b015b00
pad_small R 0 0 5c035c025c015c00
pad_small R 0 0 5d035d025d015d00
pad_small S 0
dequant_map L 4 4 1
dequant_map R 2 0 3c033c023c013c00
dequant_map R 0 0 3d033d023d013d00
dequant_map R 3 0 3e033e023e013e00
dequant_map R 1 0 3f033f023f013f00
dequant_map S 0
gid_repeat L 4 4 1
gid_repeat R 0 0 4403440244014400
gid_repeat R 0 1 deaddeaddeaddead
gid_repeat R 2 0 4603460246014600
gid_repeat R 2 1 beefbeefbeefbeef
gid_repeat S 0
zero_mask S a
clear_map C
clear_map S 0

// ==== build.f ====
+incdir+hdl
hdl/wbuf_data_pkg.sv
hdl/wbuf_ctrl_pkg.sv
hdl/wbuf_scm.sv
hdl/wbuf_buffer.sv
hdl/wbuf_ctrl.sv
hdl/wbuf_top.sv
bench/wbuf_checker.sv
bench/wbuf_tb.sv

// ==== hdl/wbuf_buffer.sv ====
// Expects exactly H load strobes per load phase, lane map persists across loads until a clear
`timescale 1ns/1ps
`include "wbuf_settings.svh"

module wbuf_buffer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  wbuf_ctrl_pkg::wbuf_ctrl_t  ctrl_i,
  output wbuf_ctrl_pkg::wbuf_flags_t flags_o,
  input  wbuf_data_pkg::row_t        w_i,
  input  wbuf_data_pkg::lane_idx_t   gidx_i,
  input  logic                       gidx_repeat_i,
  output wbuf_data_pkg::lanes_t      w_o
);

  localparam int unsigned H    = `WBUF_H;
  localparam int unsigned D    = `WBUF_D;
  localparam int unsigned ELMS = `WBUF_ELMS;
  localparam int unsigned C    = `WBUF_C;
  localparam int unsigned ElmW = $clog2(ELMS);
  localparam int unsigned ColW = $clog2(C);

  logic [$clog2(H):0]                w_row_q;
  wbuf_data_pkg::row_t               w_data;
  logic                              write_en;
  wbuf_data_pkg::lane_idx_t          write_addr;
  wbuf_data_pkg::lane_idx_t [H-1:0]  map_q;
  logic [ElmW-1:0]                   elm_q;
  logic [ColW-1:0]                   col_q;
  logic                              elm_wrap;
  wbuf_data_pkg::lanes_t             rdata;

  // Zero padding outside the programmed width and height
  for (genvar d = 0; d < D; d++) begin : gen_pad
    assign w_data[d] = (d < ctrl_i.width && w_row_q < ctrl_i.height) ? w_i[d] : '0;
  end

  assign write_en   = ctrl_i.load && !(ctrl_i.dequant && gidx_repeat_i);
  assign write_addr = ctrl_i.dequant ? gidx_i : w_row_q[$clog2(H)-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_row_q <= '0;
    end else if (clear_i || w_row_q == H) begin  // Wraps one cycle after the last row
      w_row_q <= '0;
    end else if (ctrl_i.load) begin
      w_row_q <= w_row_q + 1'b1;
    end
  end

  // Lane h reads the slot of the group it was loaded with
  for (genvar h = 0; h < H; h++) begin : gen_lane_map
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        map_q[h] <= wbuf_data_pkg::lane_idx_t'(h);
      end else if (clear_i) begin
        map_q[h] <= wbuf_data_pkg::lane_idx_t'(h);
      end else if (ctrl_i.load && ctrl_i.dequant && w_row_q == h) begin
        map_q[h] <= gidx_i;
      end
    end
  end

  assign elm_wrap = (elm_q == ElmW'(ELMS - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      elm_q <= '0;
      col_q <= '0;
    end else if (clear_i) begin
      elm_q <= '0;
      col_q <= '0;
    end else if (ctrl_i.shift) begin
      elm_q <= elm_wrap ? '0 : elm_q + 1'b1;
      if (elm_wrap) begin
        col_q <= (col_q == ColW'(C - 1)) ? '0 : col_q + 1'b1;
      end
    end
  end

  wbuf_scm i_scm (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear_i      ),
    .write_en_i   ( write_en     ),
    .write_addr_i ( write_addr   ),
    .wdata_i      ( w_data       ),
    .read_en_i    ( ctrl_i.shift ),
    .elm_addr_i   ( elm_q        ),
    .col_offs_i   ( col_q        ),
    .row_addr_i   ( map_q        ),
    .rdata_o      ( rdata        )
  );

  always_comb begin
    w_o = rdata;
    for (int h = 0; h < H; h++) begin
      if (ctrl_i.zero_set[h]) begin
        w_o[h] = '0;
      end
    end
  end

  assign flags_o.w_ready      = write_en;
  assign flags_o.gid_repeated = ctrl_i.load && ctrl_i.dequant && gidx_repeat_i;

  // The FSM must leave a gap after H rows so the counter can wrap
  a_row_cnt_bound : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (w_row_q <= H) && !(ctrl_i.load && w_row_q == H)
  ) else $error("row counter overrun");

endmodule : wbuf_buffer

// ==== hdl/wbuf_ctrl.sv ====
// No back-pressure, commands are dropped while busy and rows are ignored outside a load phase
`timescale 1ns/1ps
`include "wbuf_settings.svh"

module wbuf_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  wbuf_ctrl_pkg::cmd_t        cmd_i,
  input  logic                       cmd_valid_i,
  input  logic                       row_valid_i,
  input  wbuf_ctrl_pkg::wbuf_flags_t flags_i,
  output wbuf_ctrl_pkg::wbuf_ctrl_t  ctrl_o,
  output logic                       clear_o,
  output logic                       lanes_valid_o,
  output logic                       busy_o,
  output logic                       done_o
);

  localparam int unsigned H      = `WBUF_H;
  localparam int unsigned NShift = `WBUF_C * `WBUF_ELMS;  // Beats per stream
  localparam int unsigned RowW   = $clog2(H);
  localparam int unsigned ShW    = $clog2(NShift);

  wbuf_ctrl_pkg::ctrl_state_e state_q;
  wbuf_ctrl_pkg::ctrl_state_e state_d;
  logic [RowW-1:0]            row_cnt_q;
  logic [ShW-1:0]             shift_cnt_q;
  logic                       accept;
  logic                       load;
  logic                       shift;
  logic                       row_acc;
  logic                       load_last;
  logic                       shift_last;
  logic                       valid_q;
  logic                       last_beat_q;
  logic                       done_q;
  wbuf_ctrl_pkg::width_t      width_q;
  wbuf_ctrl_pkg::height_t     height_q;
  logic                       dequant_q;
  logic [H-1:0]               zero_set_q;

  assign accept     = cmd_valid_i && !busy_o;
  assign load       = (state_q == wbuf_ctrl_pkg::S_LOAD) && row_valid_i;
  assign shift      = (state_q == wbuf_ctrl_pkg::S_STREAM);
  assign row_acc    = flags_i.w_ready | flags_i.gid_repeated;  // Skipped rows still count
  assign load_last  = row_acc && (row_cnt_q == RowW'(H - 1));
  assign shift_last = shift && (shift_cnt_q == ShW'(NShift - 1));
  assign clear_o    = accept && (cmd_i.opcode == wbuf_ctrl_pkg::OP_CLEAR);

  always_comb begin
    state_d = state_q;
    case (state_q)
      wbuf_ctrl_pkg::S_IDLE: begin
        if (accept) begin
          case (cmd_i.opcode)
            wbuf_ctrl_pkg::OP_LOAD:   state_d = wbuf_ctrl_pkg::S_LOAD;
            wbuf_ctrl_pkg::OP_STREAM: state_d = wbuf_ctrl_pkg::S_STREAM;
            default:                  state_d = wbuf_ctrl_pkg::S_IDLE;
          endcase
        end
      end
      wbuf_ctrl_pkg::S_LOAD:   if (load_last) state_d = wbuf_ctrl_pkg::S_IDLE;
      wbuf_ctrl_pkg::S_STREAM: if (shift_last) state_d = wbuf_ctrl_pkg::S_IDLE;
      default:                 state_d = wbuf_ctrl_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= wbuf_ctrl_pkg::S_IDLE;
      row_cnt_q   <= '0;
      shift_cnt_q <= '0;
      valid_q     <= 1'b0;
      last_beat_q <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      state_q     <= state_d;
      valid_q     <= shift;       // Read is registered
      last_beat_q <= shift_last;
      done_q      <= load_last | clear_o | last_beat_q;
      if (load_last) begin
        row_cnt_q <= '0;
      end else if (row_acc) begin
        row_cnt_q <= row_cnt_q + 1'b1;
      end
      if (shift) begin
        shift_cnt_q <= shift_last ? '0 : shift_cnt_q + 1'b1;
      end
    end
  end

  // Fields held for the whole load or stream
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      width_q    <= '0;
      height_q   <= '0;
      dequant_q  <= 1'b0;
      zero_set_q <= '0;
    end else if (accept && (cmd_i.opcode == wbuf_ctrl_pkg::OP_LOAD ||
                            cmd_i.opcode == wbuf_ctrl_pkg::OP_STREAM)) begin
      width_q    <= cmd_i.width;
      height_q   <= cmd_i.height;
      dequant_q  <= cmd_i.dequant;
      zero_set_q <= cmd_i.zero_set;
    end
  end

  always_comb begin
    ctrl_o.load     = load;
    ctrl_o.shift    = shift;
    ctrl_o.dequant  = dequant_q;
    ctrl_o.width    = width_q;
    ctrl_o.height   = height_q;
    ctrl_o.zero_set = zero_set_q;
  end

  assign lanes_valid_o = valid_q;
  assign busy_o        = (state_q != wbuf_ctrl_pkg::S_IDLE) || valid_q || done_q;
  assign done_o        = done_q;

  a_load_shift_excl : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(ctrl_o.load && ctrl_o.shift)
  ) else $error("load and shift together");

  a_done_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o
  ) else $error("done longer than one cycle");

endmodule : wbuf_ctrl

// ==== hdl/wbuf_ctrl_pkg.sv ====
// Width counts elements from 0 to D and height counts rows from 0 to H
`include "wbuf_settings.svh"

package wbuf_ctrl_pkg;

  typedef enum logic [1:0] {
    OP_NOP    = 2'd0,
    OP_LOAD   = 2'd1,
    OP_STREAM = 2'd2,
    OP_CLEAR  = 2'd3
  } opcode_e;

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOAD,
    S_STREAM
  } ctrl_state_e;

  typedef logic [$clog2(`WBUF_D):0] width_t;
  typedef logic [$clog2(`WBUF_H):0] height_t;

  typedef struct packed {
    opcode_e            opcode;
    width_t             width;
    height_t            height;
    logic               dequant;
    logic [`WBUF_H-1:0] zero_set;  // Lanes forced to zero on stream
  } cmd_t;

  typedef struct packed {
    logic               load;
    logic               shift;
    logic               dequant;
    width_t             width;
    height_t            height;
    logic [`WBUF_H-1:0] zero_set;
  } wbuf_ctrl_t;

  typedef struct packed {
    logic w_ready;       // Row written this cycle
    logic gid_repeated;  // Row skipped since its group is already stored
  } wbuf_flags_t;

endpackage : wbuf_ctrl_pkg

// ==== hdl/wbuf_data_pkg.sv ====
// Layout follows wbuf_settings.svh and element 0 sits in the low bits of a row or lane vector
`include "wbuf_settings.svh"

package wbuf_data_pkg;

  // One FP16 weight or scale
  typedef logic [`WBUF_BITW-1:0] elem_t;

  // Weight row, or scale vector in dequant mode
  typedef elem_t [`WBUF_D-1:0] row_t;

  typedef elem_t [`WBUF_H-1:0] lanes_t;   // One element per lane

  // Row index or quantization group index
  typedef logic [$clog2(`WBUF_H)-1:0] lane_idx_t;

endpackage : wbuf_data_pkg

// ==== hdl/wbuf_scm.sv ====
// Storage rows have no reset and read as X until written, clear only zeroes the read register
`timescale 1ns/1ps
`include "wbuf_settings.svh"

module wbuf_scm (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   clear_i,
  input  logic                                   write_en_i,
  input  wbuf_data_pkg::lane_idx_t               write_addr_i,
  input  wbuf_data_pkg::row_t                    wdata_i,
  input  logic                                   read_en_i,
  input  logic [$clog2(`WBUF_ELMS)-1:0]          elm_addr_i,
  input  logic [$clog2(`WBUF_C)-1:0]             col_offs_i,
  input  wbuf_data_pkg::lane_idx_t [`WBUF_H-1:0] row_addr_i,
  output wbuf_data_pkg::lanes_t                  rdata_o
);

  localparam int unsigned H    = `WBUF_H;
  localparam int unsigned D    = `WBUF_D;
  localparam int unsigned ELMS = `WBUF_ELMS;
  localparam int unsigned IdxW = $clog2(D);

  wbuf_data_pkg::row_t   mem_q [H];
  wbuf_data_pkg::lanes_t rdata_q;
  logic [IdxW-1:0]       rd_idx;

  // Section major, element minor
  assign rd_idx = IdxW'(col_offs_i * ELMS + elm_addr_i);

  always_ff @(posedge clk_i) begin
    if (write_en_i) begin
      mem_q[write_addr_i] <= wdata_i;
    end
  end

  // Each lane reads from its own row
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (clear_i) begin
      rdata_q <= '0;
    end else if (read_en_i) begin
      for (int h = 0; h < H; h++) begin
        rdata_q[h] <= mem_q[row_addr_i[h]][rd_idx];
      end
    end
  end

  assign rdata_o = rdata_q;

  // Clear comes from the FSM and must never collide with a row write
  a_no_write_on_clear : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    clear_i |-> !write_en_i
  ) else $error("row write during clear");

endmodule : wbuf_scm

// ==== hdl/wbuf_settings.svh ====
// D, H and ELMS must be powers of two and C*ELMS must equal D, FP16 elements only
`ifndef WBUF_SETTINGS_SVH
`define WBUF_SETTINGS_SVH

`define WBUF_H      4   // Lanes, also buffer rows
`define WBUF_NREGS  1   // Pipe registers per PE
`define WBUF_BITW   16  // Element width
`define WBUF_DW     64  // Input row width

`define WBUF_ELMS   (`WBUF_NREGS + 1)
`define WBUF_D      (`WBUF_DW / `WBUF_BITW)
`define WBUF_C      ((`WBUF_D + `WBUF_NREGS) / `WBUF_ELMS)

`endif

// ==== hdl/wbuf_top.sv ====
// Rows and group indices are sampled only on row_valid_i in a load phase, outputs valid with lanes_valid_o
`timescale 1ns/1ps

module wbuf_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  wbuf_ctrl_pkg::cmd_t      cmd_i,
  input  logic                     cmd_valid_i,
  input  wbuf_data_pkg::row_t      row_i,
  input  logic                     row_valid_i,
  input  wbuf_data_pkg::lane_idx_t gidx_i,
  input  logic                     gidx_repeat_i,
  output wbuf_data_pkg::lanes_t    lanes_o,
  output logic                     lanes_valid_o,
  output logic                     busy_o,
  output logic                     done_o
);

  wbuf_ctrl_pkg::wbuf_ctrl_t  ctrl;
  wbuf_ctrl_pkg::wbuf_flags_t flags;
  logic                       clear;

  wbuf_ctrl i_ctrl (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .cmd_i         ( cmd_i         ),
    .cmd_valid_i   ( cmd_valid_i   ),
    .row_valid_i   ( row_valid_i   ),
    .flags_i       ( flags         ),
    .ctrl_o        ( ctrl          ),
    .clear_o       ( clear         ),
    .lanes_valid_o ( lanes_valid_o ),
    .busy_o        ( busy_o        ),
    .done_o        ( done_o        )
  );

  wbuf_buffer i_buffer (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear         ),
    .ctrl_i        ( ctrl          ),
    .flags_o       ( flags         ),
    .w_i           ( row_i         ),
    .gidx_i        ( gidx_i        ),
    .gidx_repeat_i ( gidx_repeat_i ),
    .w_o           ( lanes_o       )
  );

endmodule : wbuf_top

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module wbuf_tb -o wbuf_sim \
  && ./obj_dir/wbuf_sim > sim.log 2>&1 \
  || { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^TESTS PASSED$" sim.log \
  && echo "Simulation run succeeded" \
  || { echo "Simulation run reported failure"; exit 1; }
